//--- include/cpu_params.svh
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// register and data width
`define CPU_XLEN 32

// word address widths, 64 words each
`define CPU_IMEM_AW 6
`define CPU_DMEM_AW 6

`endif

//--- src/cpu_pkg.sv
package cpu_pkg;

	// instruction class, picks result and next-pc source in execute
	typedef enum logic [3:0] {
		CLASS_ALU    = 4'd0,
		CLASS_LUI    = 4'd1,
		CLASS_AUIPC  = 4'd2,
		CLASS_JAL    = 4'd3,
		CLASS_JALR   = 4'd4,
		CLASS_BRANCH = 4'd5,
		CLASS_LOAD   = 4'd6,
		CLASS_STORE  = 4'd7
	} op_class_t;

	typedef enum logic [3:0] {
		ALU_ADD  = 4'd0,
		ALU_SUB  = 4'd1,
		ALU_SLL  = 4'd2,
		ALU_SLT  = 4'd3,
		ALU_SLTU = 4'd4,
		ALU_XOR  = 4'd5,
		ALU_SRL  = 4'd6,
		ALU_SRA  = 4'd7,
		ALU_OR   = 4'd8,
		ALU_AND  = 4'd9,
		ALU_EQ   = 4'd10, // branch compares from here
		ALU_NE   = 4'd11,
		ALU_LT   = 4'd12,
		ALU_GE   = 4'd13,
		ALU_LTU  = 4'd14,
		ALU_GEU  = 4'd15
	} alu_op_t;

	// second alu operand
	typedef enum logic {
		SEL_RS2 = 1'b0,
		SEL_IMM = 1'b1
	} operand_sel_t;

endpackage

//--- src/cpu_fetch.sv
`include "cpu_params.svh"

`timescale 1ns/100ps

module cpu_fetch (
	input  logic                     i_clock,
	input  logic                     i_reset,
	input  logic                     i_run,
	input  logic                     i_load_we,
	input  logic [`CPU_IMEM_AW-1:0]  i_load_addr,
	input  logic [31:0]              i_load_data,
	input  logic                     i_retire,
	input  logic [`CPU_XLEN-1:0]     i_next_pc,
	output logic [`CPU_XLEN-1:0]     o_pc,
	output logic [31:0]              o_instruction,
	output logic                     o_tag
);

	logic [31:0] imem [0:(1 << `CPU_IMEM_AW)-1];
	logic run_q;
	logic read_req;

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			o_pc <= '0;
			o_tag <= 1'b0;
			run_q <= 1'b0;
			read_req <= 1'b0;
		end else begin
			run_q <= i_run;
			read_req <= 1'b0;
			if (i_run && !run_q) begin
				o_pc <= '0; // start of program
				read_req <= 1'b1;
			end else if (i_retire) begin
				o_pc <= i_next_pc;
				read_req <= 1'b1;
			end
			if (read_req)
				o_tag <= ~o_tag; // word is valid with the toggle
		end
	end

	always_ff @(posedge i_clock) begin
		if (i_load_we && !i_run)
			imem[i_load_addr] <= i_load_data;
		if (read_req)
			o_instruction <= imem[o_pc[`CPU_IMEM_AW+1:2]];
	end

endmodule

//--- src/cpu_decode.sv
`include "cpu_params.svh"

`timescale 1ns/100ps

module cpu_decode (
	input  logic                  i_clock,
	input  logic                  i_reset,
	input  logic                  i_busy,
	input  logic [`CPU_XLEN-1:0]  i_pc,
	input  logic [31:0]           i_instruction,
	input  logic                  i_tag,
	output logic                  o_fault,
	output logic [`CPU_XLEN-1:0]  o_pc,
	output logic [4:0]            o_rs1,
	output logic [4:0]            o_rs2,
	output logic [4:0]            o_rd,
	output logic [`CPU_XLEN-1:0]  o_imm,
	output cpu_pkg::op_class_t    o_class,
	output cpu_pkg::alu_op_t      o_alu_op,
	output cpu_pkg::operand_sel_t o_operand_sel,
	output logic                  o_tag
);

	import cpu_pkg::*;

	typedef enum logic [6:0] {
		OPC_LUI    = 7'b0110111,
		OPC_AUIPC  = 7'b0010111,
		OPC_JAL    = 7'b1101111,
		OPC_JALR   = 7'b1100111,
		OPC_BRANCH = 7'b1100011,
		OPC_LOAD   = 7'b0000011,
		OPC_STORE  = 7'b0100011,
		OPC_OP_IMM = 7'b0010011,
		OPC_OP     = 7'b0110011
	} opcode_t;

	opcode_t opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic [`CPU_XLEN-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;
	op_class_t dec_class;
	alu_op_t dec_alu_op;
	operand_sel_t dec_sel;
	logic [`CPU_XLEN-1:0] dec_imm;
	logic dec_legal;
	logic new_instr;

	assign opcode = opcode_t'(i_instruction[6:0]);
	assign funct3 = i_instruction[14:12];
	assign funct7 = i_instruction[31:25];

	assign imm_i = {{(`CPU_XLEN-11){i_instruction[31]}}, i_instruction[30:20]};
	assign imm_s = {{(`CPU_XLEN-11){i_instruction[31]}}, i_instruction[30:25],
		i_instruction[11:7]};
	assign imm_b = {{(`CPU_XLEN-12){i_instruction[31]}}, i_instruction[7],
		i_instruction[30:25], i_instruction[11:8], 1'b0};
	assign imm_u = {i_instruction[31:12], 12'b0};
	assign imm_j = {{(`CPU_XLEN-20){i_instruction[31]}}, i_instruction[19:12],
		i_instruction[20], i_instruction[30:21], 1'b0};

	function automatic alu_op_t arith_op(input logic [2:0] f3, input logic alt);
		case (f3)
			3'b000: arith_op = alt ? ALU_SUB : ALU_ADD;
			3'b001: arith_op = ALU_SLL;
			3'b010: arith_op = ALU_SLT;
			3'b011: arith_op = ALU_SLTU;
			3'b100: arith_op = ALU_XOR;
			3'b101: arith_op = alt ? ALU_SRA : ALU_SRL;
			3'b110: arith_op = ALU_OR;
			default: arith_op = ALU_AND;
		endcase
	endfunction

	function automatic alu_op_t branch_op(input logic [2:0] f3);
		case (f3)
			3'b000: branch_op = ALU_EQ;
			3'b001: branch_op = ALU_NE;
			3'b100: branch_op = ALU_LT;
			3'b101: branch_op = ALU_GE;
			3'b110: branch_op = ALU_LTU;
			default: branch_op = ALU_GEU;
		endcase
	endfunction

	always_comb begin
		dec_class = CLASS_ALU;
		dec_alu_op = ALU_ADD;
		dec_sel = SEL_IMM;
		dec_imm = imm_i;
		dec_legal = 1'b0;
		case (opcode)
			OPC_LUI: begin
				dec_class = CLASS_LUI;
				dec_imm = imm_u;
				dec_legal = 1'b1;
			end
			OPC_AUIPC: begin
				dec_class = CLASS_AUIPC;
				dec_imm = imm_u;
				dec_legal = 1'b1;
			end
			OPC_JAL: begin
				dec_class = CLASS_JAL;
				dec_imm = imm_j;
				dec_legal = 1'b1;
			end
			OPC_JALR: begin
				dec_class = CLASS_JALR;
				dec_legal = (funct3 == 3'b000);
			end
			OPC_BRANCH: begin
				dec_class = CLASS_BRANCH;
				dec_alu_op = branch_op(funct3);
				dec_sel = SEL_RS2;
				dec_imm = imm_b;
				dec_legal = (funct3[2:1] != 2'b01);
			end
			OPC_LOAD: begin
				dec_class = CLASS_LOAD;
				dec_legal = (funct3 == 3'b010); // word only
			end
			OPC_STORE: begin
				dec_class = CLASS_STORE;
				dec_imm = imm_s;
				dec_legal = (funct3 == 3'b010);
			end
			OPC_OP_IMM: begin
				// alt bit only matters for shifts, addi has no sub form
				dec_alu_op = arith_op(funct3, funct3 == 3'b101 && funct7[5]);
				if (funct3 == 3'b001)
					dec_legal = (funct7 == 7'b0000000);
				else if (funct3 == 3'b101)
					dec_legal = (funct7 == 7'b0000000 || funct7 == 7'b0100000);
				else
					dec_legal = 1'b1;
			end
			OPC_OP: begin
				dec_alu_op = arith_op(funct3, funct7[5]);
				dec_sel = SEL_RS2;
				dec_legal = (funct7 == 7'b0000000) ||
					(funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101));
			end
			default: dec_legal = 1'b0;
		endcase
	end

	assign new_instr = (i_tag != o_tag) && !o_fault;

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			o_tag <= 1'b0;
			o_fault <= 1'b0;
			o_class <= CLASS_ALU;
		end else if (new_instr) begin
			o_class <= dec_class;
			if (dec_legal)
				o_tag <= i_tag; // hand to execute
			else
				o_fault <= 1'b1; // sticky, instruction dropped
		end
	end

	always_ff @(posedge i_clock) begin
		if (new_instr) begin
			o_pc <= i_pc;
			o_rs1 <= i_instruction[19:15];
			o_rs2 <= i_instruction[24:20];
			o_rd <= i_instruction[11:7];
			o_imm <= dec_imm;
			o_alu_op <= dec_alu_op;
			o_operand_sel <= dec_sel;
		end
	end

	// fetch only issues after retire, so execute is idle when a word arrives
	a_no_tag_while_busy: assert property (@(posedge i_clock) disable iff (i_reset)
		(i_tag != o_tag) |-> !i_busy)
		else $error("new instruction while execute busy");

	a_class_known: assert property (@(posedge i_clock) disable iff (i_reset)
		!$isunknown(o_class))
		else $error("o_class unknown");

endmodule

//--- src/cpu_regfile.sv
`include "cpu_params.svh"

`timescale 1ns/100ps

module cpu_regfile (
	input  logic                  i_clock,
	input  logic                  i_reset,
	input  logic [4:0]            i_rs1,
	input  logic [4:0]            i_rs2,
	output logic [`CPU_XLEN-1:0]  o_rs1_value,
	output logic [`CPU_XLEN-1:0]  o_rs2_value,
	input  logic                  i_we,
	input  logic [4:0]            i_rd,
	input  logic [`CPU_XLEN-1:0]  i_wdata
);

	logic [`CPU_XLEN-1:0] regs [1:31]; // no storage for x0

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			for (int i = 1; i < 32; i++)
				regs[i] <= '0;
		end else if (i_we && i_rd != 5'd0) begin
			regs[i_rd] <= i_wdata;
		end
	end

	assign o_rs1_value = (i_rs1 == 5'd0) ? '0 : regs[i_rs1];
	assign o_rs2_value = (i_rs2 == 5'd0) ? '0 : regs[i_rs2];

endmodule

//--- src/cpu_execute.sv
`include "cpu_params.svh"

`timescale 1ns/100ps

module cpu_execute (
	input  logic                  i_clock,
	input  logic                  i_reset,
	input  logic [`CPU_XLEN-1:0]  i_pc,
	input  logic [4:0]            i_rs1,
	input  logic [4:0]            i_rs2,
	input  logic [4:0]            i_rd,
	input  logic [`CPU_XLEN-1:0]  i_imm,
	input  cpu_pkg::op_class_t    i_class,
	input  cpu_pkg::alu_op_t      i_alu_op,
	input  cpu_pkg::operand_sel_t i_operand_sel,
	input  logic                  i_tag,
	input  logic [`CPU_XLEN-1:0]  i_rs1_value,
	input  logic [`CPU_XLEN-1:0]  i_rs2_value,
	output logic                  o_busy,
	output logic                  o_we,
	output logic [4:0]            o_rd,
	output logic [`CPU_XLEN-1:0]  o_wdata,
	output logic                  o_retire,
	output logic [`CPU_XLEN-1:0]  o_retire_pc,
	output logic [`CPU_XLEN-1:0]  o_next_pc
);

	import cpu_pkg::*;

	logic [`CPU_XLEN-1:0] dmem [0:(1 << `CPU_DMEM_AW)-1];
	logic [`CPU_XLEN-1:0] rs1_value, rs2_value, operand_b, alu_result;
	logic [`CPU_XLEN-1:0] link_pc, pc_target, addr_sum, result, next_pc, dmem_rdata;
	logic tag_q;
	logic start;
	logic retire_now;
	logic writes_rd;

	assign rs1_value = (i_rs1 == 5'd0) ? '0 : i_rs1_value;
	assign rs2_value = (i_rs2 == 5'd0) ? '0 : i_rs2_value;
	assign operand_b = (i_operand_sel == SEL_IMM) ? i_imm : rs2_value;
	assign link_pc = i_pc + 4;
	assign pc_target = i_pc + i_imm;
	assign addr_sum = rs1_value + i_imm; // load/store address and jalr target

	assign start = (i_tag != tag_q);
	assign retire_now = (start && i_class != CLASS_LOAD) || o_busy;

	always_comb begin
		case (i_alu_op)
			ALU_ADD:  alu_result = rs1_value + operand_b;
			ALU_SUB:  alu_result = rs1_value - operand_b;
			ALU_SLL:  alu_result = rs1_value << operand_b[4:0];
			ALU_SLT:  alu_result = {31'b0, $signed(rs1_value) < $signed(operand_b)};
			ALU_SLTU: alu_result = {31'b0, rs1_value < operand_b};
			ALU_XOR:  alu_result = rs1_value ^ operand_b;
			ALU_SRL:  alu_result = rs1_value >> operand_b[4:0];
			ALU_SRA:  alu_result = $signed(rs1_value) >>> operand_b[4:0];
			ALU_OR:   alu_result = rs1_value | operand_b;
			ALU_AND:  alu_result = rs1_value & operand_b;
			ALU_EQ:   alu_result = {31'b0, rs1_value == operand_b};
			ALU_NE:   alu_result = {31'b0, rs1_value != operand_b};
			ALU_LT:   alu_result = {31'b0, $signed(rs1_value) < $signed(operand_b)};
			ALU_GE:   alu_result = {31'b0, $signed(rs1_value) >= $signed(operand_b)};
			ALU_LTU:  alu_result = {31'b0, rs1_value < operand_b};
			default:  alu_result = {31'b0, rs1_value >= operand_b};
		endcase
	end

	always_comb begin
		result = alu_result;
		next_pc = link_pc;
		writes_rd = 1'b1;
		case (i_class)
			CLASS_LUI: result = i_imm;
			CLASS_AUIPC: result = pc_target;
			CLASS_JAL: begin
				result = link_pc;
				next_pc = pc_target;
			end
			CLASS_JALR: begin
				result = link_pc;
				next_pc = {addr_sum[`CPU_XLEN-1:1], 1'b0};
			end
			CLASS_BRANCH: begin
				writes_rd = 1'b0;
				if (alu_result[0])
					next_pc = pc_target; // taken
			end
			CLASS_STORE: writes_rd = 1'b0;
			default: ;
		endcase
	end

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			tag_q <= 1'b0;
			o_busy <= 1'b0;
			o_retire <= 1'b0;
			o_we <= 1'b0;
		end else begin
			o_retire <= 1'b0;
			o_we <= 1'b0;
			if (start)
				tag_q <= i_tag;
			if (start && i_class == CLASS_LOAD) begin
				o_busy <= 1'b1; // wait for dmem read
			end else if (retire_now) begin
				o_busy <= 1'b0;
				o_retire <= 1'b1;
				o_we <= writes_rd;
			end
		end
	end

	always_ff @(posedge i_clock) begin
		if (retire_now) begin
			o_rd <= i_rd;
			o_retire_pc <= i_pc;
			o_next_pc <= next_pc;
			if (!writes_rd || i_rd == 5'd0)
				o_wdata <= '0;
			else
				o_wdata <= o_busy ? dmem_rdata : result;
		end
	end

	always_ff @(posedge i_clock) begin
		if (start && i_class == CLASS_STORE)
			dmem[addr_sum[`CPU_DMEM_AW+1:2]] <= rs2_value;
		if (start)
			dmem_rdata <= dmem[addr_sum[`CPU_DMEM_AW+1:2]];
	end

	a_single_retire: assert property (@(posedge i_clock) disable iff (i_reset)
		o_retire |=> !o_retire)
		else $error("retire held for two cycles");

endmodule

//--- src/cpu_top.sv
`include "cpu_params.svh"

`timescale 1ns/100ps

module cpu_top (
	input  logic                    i_clock,
	input  logic                    i_reset,
	input  logic                    i_run,
	input  logic                    i_load_we,
	input  logic [`CPU_IMEM_AW-1:0] i_load_addr,
	input  logic [31:0]             i_load_data,
	output logic                    o_fault,
	output logic                    o_retire_valid,
	output logic [`CPU_XLEN-1:0]    o_retire_pc,
	output logic [4:0]              o_retire_rd,
	output logic                    o_retire_we,
	output logic [`CPU_XLEN-1:0]    o_retire_value
);

	import cpu_pkg::*;

	// fetch to decode
	logic [`CPU_XLEN-1:0] fetch_pc;
	logic [31:0] fetch_instruction;
	logic fetch_tag;

	// decode to execute
	logic [`CPU_XLEN-1:0] dec_pc, dec_imm;
	logic [4:0] dec_rs1, dec_rs2, dec_rd;
	op_class_t dec_class;
	alu_op_t dec_alu_op;
	operand_sel_t dec_operand_sel;
	logic dec_tag;

	logic exe_busy;
	logic [`CPU_XLEN-1:0] exe_next_pc;
	logic [`CPU_XLEN-1:0] rs1_value, rs2_value;

	cpu_fetch u_fetch (
		.i_clock       (i_clock),
		.i_reset       (i_reset),
		.i_run         (i_run),
		.i_load_we     (i_load_we),
		.i_load_addr   (i_load_addr),
		.i_load_data   (i_load_data),
		.i_retire      (o_retire_valid),
		.i_next_pc     (exe_next_pc),
		.o_pc          (fetch_pc),
		.o_instruction (fetch_instruction),
		.o_tag         (fetch_tag)
	);

	cpu_decode u_decode (
		.i_clock       (i_clock),
		.i_reset       (i_reset),
		.i_busy        (exe_busy),
		.i_pc          (fetch_pc),
		.i_instruction (fetch_instruction),
		.i_tag         (fetch_tag),
		.o_fault       (o_fault),
		.o_pc          (dec_pc),
		.o_rs1         (dec_rs1),
		.o_rs2         (dec_rs2),
		.o_rd          (dec_rd),
		.o_imm         (dec_imm),
		.o_class       (dec_class),
		.o_alu_op      (dec_alu_op),
		.o_operand_sel (dec_operand_sel),
		.o_tag         (dec_tag)
	);

	cpu_regfile u_regfile (
		.i_clock     (i_clock),
		.i_reset     (i_reset),
		.i_rs1       (dec_rs1),
		.i_rs2       (dec_rs2),
		.o_rs1_value (rs1_value),
		.o_rs2_value (rs2_value),
		.i_we        (o_retire_we),
		.i_rd        (o_retire_rd),
		.i_wdata     (o_retire_value)
	);

	cpu_execute u_execute (
		.i_clock       (i_clock),
		.i_reset       (i_reset),
		.i_pc          (dec_pc),
		.i_rs1         (dec_rs1),
		.i_rs2         (dec_rs2),
		.i_rd          (dec_rd),
		.i_imm         (dec_imm),
		.i_class       (dec_class),
		.i_alu_op      (dec_alu_op),
		.i_operand_sel (dec_operand_sel),
		.i_tag         (dec_tag),
		.i_rs1_value   (rs1_value),
		.i_rs2_value   (rs2_value),
		.o_busy        (exe_busy),
		.o_we          (o_retire_we),
		.o_rd          (o_retire_rd),
		.o_wdata       (o_retire_value),
		.o_retire      (o_retire_valid),
		.o_retire_pc   (o_retire_pc),
		.o_next_pc     (exe_next_pc)
	);

endmodule

//--- tests/cpu_tb.sv
`include "cpu_params.svh"

`timescale 1ns/100ps

module cpu_tb;

	localparam logic [6:0] OPC_LUI = 7'h37;
	localparam logic [6:0] OPC_AUIPC = 7'h17;
	localparam logic [6:0] OPC_JAL = 7'h6f;
	localparam logic [6:0] OPC_JALR = 7'h67;
	localparam logic [6:0] OPC_BRANCH = 7'h63;
	localparam logic [6:0] OPC_LOAD = 7'h03;
	localparam logic [6:0] OPC_STORE = 7'h23;
	localparam logic [6:0] OPC_IMM = 7'h13;
	localparam logic [6:0] OPC_REG = 7'h33;

	localparam int ALU_COUNT = 24;
	localparam int RETIRE_TOTAL = ALU_COUNT + 8 + 19 + 13 + 2; // retires over all tests
	localparam int CYCLE_LIMIT = 20 * RETIRE_TOTAL;

	logic i_clock, i_reset, i_run, i_load_we;
	logic [`CPU_IMEM_AW-1:0] i_load_addr;
	logic [31:0] i_load_data;
	logic o_fault, o_retire_valid, o_retire_we;
	logic [31:0] o_retire_pc, o_retire_value;
	logic [4:0] o_retire_rd;

	logic [31:0] prog [$];
	logic [31:0] model_regs [0:31];
	logic [31:0] model_mem [0:(1 << `CPU_DMEM_AW)-1]; // kept across tests like dmem
	logic [31:0] model_pc;
	logic [31:0] lcg_state;
	int run_cycles = 0;

	cpu_top UUT (
		.i_clock        (i_clock),
		.i_reset        (i_reset),
		.i_run          (i_run),
		.i_load_we      (i_load_we),
		.i_load_addr    (i_load_addr),
		.i_load_data    (i_load_data),
		.o_fault        (o_fault),
		.o_retire_valid (o_retire_valid),
		.o_retire_pc    (o_retire_pc),
		.o_retire_rd    (o_retire_rd),
		.o_retire_we    (o_retire_we),
		.o_retire_value (o_retire_value)
	);

	initial begin
		i_clock = 1'b0;
		forever #2 i_clock = ~i_clock;
	end

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("Verification failed");
		$fatal(1);
	endtask

	always @(posedge i_clock) begin
		if (i_run)
			run_cycles <= run_cycles + 1;
		if (run_cycles > CYCLE_LIMIT)
			fail_run($sformatf("timeout, core still running after %0d cycles", CYCLE_LIMIT));
	end

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp)
			fail_run($sformatf("** Error at %0t: %s = %h, expected %h", $time, name, got, exp));
	endtask

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [2:0] f3,
		input logic [4:0] rd, input logic [4:0] rs1, input logic [4:0] rs2);
		return {f7, rs2, rs1, f3, rd, OPC_REG};
	endfunction

	function automatic logic [31:0] enc_i(input logic [6:0] op, input logic [2:0] f3,
		input logic [4:0] rd, input logic [4:0] rs1, input logic [31:0] imm);
		return {imm[11:0], rs1, f3, rd, op};
	endfunction

	function automatic logic [31:0] enc_s(input logic [4:0] rs1, input logic [4:0] rs2,
		input logic [31:0] imm);
		return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OPC_STORE};
	endfunction

	function automatic logic [31:0] enc_b(input logic [2:0] f3, input logic [4:0] rs1,
		input logic [4:0] rs2, input logic [31:0] imm);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
	endfunction

	function automatic logic [31:0] enc_u(input logic [6:0] op, input logic [4:0] rd,
		input logic [19:0] imm);
		return {imm, rd, op};
	endfunction

	function automatic logic [31:0] enc_j(input logic [4:0] rd, input logic [31:0] imm);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
	endfunction

	function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
		input logic [31:0] a, input logic [31:0] b);
		case (f3)
			3'd0: return alt ? a - b : a + b;
			3'd1: return a << b[4:0];
			3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			3'd3: return (a < b) ? 32'd1 : 32'd0;
			3'd4: return a ^ b;
			3'd5: begin
				if (alt)
					return $signed(a) >>> b[4:0];
				return a >> b[4:0];
			end
			3'd6: return a | b;
			default: return a & b;
		endcase
	endfunction

	// executes one instruction of prog and reports what should retire
	task automatic model_step(output logic [31:0] pc, output logic we,
		output logic [4:0] rd, output logic [31:0] value);
		logic [31:0] ins, a, b, imm_i, imm_s, imm_b, imm_j, res, next, addr;
		logic [2:0] f3;
		logic taken;
		ins = prog[model_pc >> 2];
		f3 = ins[14:12];
		a = model_regs[ins[19:15]];
		b = model_regs[ins[24:20]];
		imm_i = {{20{ins[31]}}, ins[31:20]};
		imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
		imm_b = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
		imm_j = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
		pc = model_pc;
		rd = ins[11:7];
		we = 1'b1;
		res = '0;
		next = model_pc + 4;
		case (ins[6:0])
			OPC_LUI: res = {ins[31:12], 12'b0};
			OPC_AUIPC: res = model_pc + {ins[31:12], 12'b0};
			OPC_JAL: begin
				res = model_pc + 4;
				next = model_pc + imm_j;
			end
			OPC_JALR: begin
				res = model_pc + 4;
				next = (a + imm_i) & ~32'd1;
			end
			OPC_BRANCH: begin
				we = 1'b0;
				case (f3)
					3'b000: taken = (a == b);
					3'b001: taken = (a != b);
					3'b100: taken = ($signed(a) < $signed(b));
					3'b101: taken = ($signed(a) >= $signed(b));
					3'b110: taken = (a < b);
					default: taken = (a >= b);
				endcase
				if (taken)
					next = model_pc + imm_b;
			end
			OPC_LOAD: begin
				addr = a + imm_i;
				res = model_mem[addr[`CPU_DMEM_AW+1:2]];
			end
			OPC_STORE: begin
				we = 1'b0;
				addr = a + imm_s;
				model_mem[addr[`CPU_DMEM_AW+1:2]] = b;
			end
			OPC_IMM: res = alu_ref(f3, f3 == 3'b101 && ins[30], a, imm_i);
			default: res = alu_ref(f3, ins[30], a, b);
		endcase
		if (we && rd != 5'd0)
			model_regs[rd] = res;
		value = (rd == 5'd0) ? 32'd0 : res;
		model_pc = next;
	endtask

	task automatic load_program();
		@(negedge i_clock);
		i_run = 1'b0;
		for (int a = 0; a < (1 << `CPU_IMEM_AW); a++) begin
			i_load_we = 1'b1;
			i_load_addr = a;
			// unused words hold an unsupported opcode, tagged with the address
			i_load_data = (a < prog.size()) ? prog[a] : {25'(a), 7'h7f};
			@(negedge i_clock);
		end
		i_load_we = 1'b0;
	endtask

	task automatic apply_reset();
		i_reset = 1'b1;
		repeat (10) @(negedge i_clock);
		i_reset = 1'b0;
	endtask

	task automatic wait_retire();
		@(negedge i_clock);
		while (!o_retire_valid) begin
			if (o_fault)
				fail_run("o_fault rose while the program was still running");
			@(negedge i_clock);
		end
	endtask

	// load, reset, start and follow the model until its pc reaches word stop_word
	task automatic run_program(input int stop_word);
		logic [31:0] exp_pc, exp_value;
		logic [4:0] exp_rd;
		logic exp_we;
		load_program();
		for (int r = 0; r < 32; r++)
			model_regs[r] = '0;
		model_pc = '0;
		apply_reset();
		i_run = 1'b1;
		while ((model_pc >> 2) < stop_word) begin
			wait_retire();
			model_step(exp_pc, exp_we, exp_rd, exp_value);
			check_value("o_retire_pc", o_retire_pc, exp_pc);
			check_value("o_retire_we", o_retire_we, exp_we);
			if (exp_we) begin
				check_value("o_retire_rd", o_retire_rd, exp_rd);
				check_value("o_retire_value", o_retire_value, exp_value);
			end
		end
	endtask

	task automatic test_alu_random();
		logic [31:0] r, r2, imm;
		logic [2:0] f3;
		logic alt;
		prog.delete();
		lcg_state = 32'hc3dd;
		for (int i = 0; i < ALU_COUNT; i++) begin
			r = lcg_next();
			r2 = lcg_next();
			f3 = r[15:13];
			alt = r[31];
			case (r[12:10])
				3'd0: prog.push_back(enc_u(OPC_LUI, r[20:16], r2[31:12]));
				3'd1: prog.push_back(enc_u(OPC_AUIPC, r[20:16], r2[31:12]));
				3'd2, 3'd3, 3'd4: begin
					if (f3 == 3'b001)
						imm = {27'b0, r2[24:20]};
					else if (f3 == 3'b101)
						imm = {21'b0, alt, 5'b0, r2[24:20]}; // srai when alt
					else
						imm = {20'b0, r2[31:20]};
					prog.push_back(enc_i(OPC_IMM, f3, r[20:16], r[25:21], imm));
				end
				default: prog.push_back(enc_r((alt && (f3 == 3'b000 || f3 == 3'b101)) ?
					7'h20 : 7'h00, f3, r[20:16], r[25:21], r[30:26]));
			endcase
		end
		run_program(prog.size());
	endtask

	task automatic test_x0();
		prog.delete();
		prog.push_back(enc_i(OPC_IMM, 3'b000, 0, 0, 123));
		prog.push_back(enc_u(OPC_LUI, 0, 20'h12345));
		prog.push_back(enc_i(OPC_IMM, 3'b000, 5, 0, 7));
		prog.push_back(enc_r(7'h00, 3'b000, 6, 0, 0));
		prog.push_back(enc_r(7'h00, 3'b000, 0, 5, 5));
		prog.push_back(enc_r(7'h00, 3'b000, 9, 0, 5));
		prog.push_back(enc_j(0, 8)); // link dropped
		prog.push_back(enc_i(OPC_IMM, 3'b000, 7, 0, 1));
		prog.push_back(enc_r(7'h00, 3'b110, 8, 0, 5));
		run_program(prog.size());
	endtask

	task automatic test_branches();
		prog.delete();
		prog.push_back(enc_i(OPC_IMM, 3'b000, 1, 0, 0));
		prog.push_back(enc_i(OPC_IMM, 3'b000, 2, 0, 5));
		prog.push_back(enc_i(OPC_IMM, 3'b000, 1, 1, 1)); // loop body
		prog.push_back(enc_b(3'b100, 1, 2, -4));
		prog.push_back(enc_i(OPC_IMM, 3'b000, 3, 0, -1));
		prog.push_back(enc_b(3'b111, 3, 2, 8));
		prog.push_back(enc_i(OPC_IMM, 3'b000, 4, 0, 99));
		prog.push_back(enc_b(3'b001, 1, 2, 8)); // falls through
		prog.push_back(enc_j(5, 12));
		prog.push_back(enc_i(OPC_IMM, 3'b000, 6, 0, 1));
		prog.push_back(enc_j(0, 12));
		prog.push_back(enc_i(OPC_JALR, 3'b000, 7, 5, 5)); // odd target, bit 0 dropped
		prog.push_back(enc_i(OPC_IMM, 3'b000, 9, 0, 9));
		prog.push_back(enc_r(7'h00, 3'b000, 8, 1, 7));
		run_program(prog.size());
	endtask

	task automatic test_load_store();
		prog.delete();
		prog.push_back(enc_u(OPC_LUI, 1, 20'h12345));
		prog.push_back(enc_i(OPC_IMM, 3'b000, 1, 1, 12'h678));
		prog.push_back(enc_i(OPC_IMM, 3'b000, 2, 0, 16));
		prog.push_back(enc_s(2, 1, 0));
		prog.push_back(enc_i(OPC_IMM, 3'b000, 3, 0, -5));
		prog.push_back(enc_s(2, 3, 8));
		prog.push_back(enc_s(2, 2, -4));
		prog.push_back(enc_i(OPC_LOAD, 3'b010, 4, 2, 0));
		prog.push_back(enc_i(OPC_LOAD, 3'b010, 5, 2, 8));
		prog.push_back(enc_i(OPC_LOAD, 3'b010, 6, 2, -4));
		prog.push_back(enc_b(3'b000, 4, 1, 8));
		prog.push_back(enc_i(OPC_IMM, 3'b000, 7, 0, 1));
		prog.push_back(enc_s(0, 5, 40));
		prog.push_back(enc_i(OPC_LOAD, 3'b010, 8, 0, 40));
		run_program(prog.size());
	endtask

	task automatic test_illegal();
		int waited;
		prog.delete();
		prog.push_back(enc_i(OPC_IMM, 3'b000, 1, 0, 3));
		prog.push_back(enc_r(7'h00, 3'b000, 2, 1, 1));
		prog.push_back(32'h0000_0073); // ecall, not supported
		run_program(prog.size() - 1);
		waited = 0;
		while (!o_fault && waited < 20) begin
			@(negedge i_clock);
			check_value("o_retire_valid", o_retire_valid, 0);
			waited++;
		end
		if (!o_fault)
			fail_run("o_fault did not rise after the unsupported instruction");
		repeat (20) begin
			@(negedge i_clock);
			check_value("o_fault", o_fault, 1);
			check_value("o_retire_valid", o_retire_valid, 0);
		end
	endtask

	initial begin
		i_reset = 1'b1;
		i_run = 1'b0;
		i_load_we = 1'b0;
		i_load_addr = '0;
		i_load_data = '0;
		lcg_state = 32'hc3dd;
		test_alu_random();
		test_x0();
		test_branches();
		test_load_store();
		test_illegal();
		$display("Verification passed");
		$finish;
	end

endmodule

//--- src.f
+incdir+include
src/cpu_pkg.sv
src/cpu_fetch.sv
src/cpu_decode.sv
src/cpu_regfile.sv
src/cpu_execute.sv
src/cpu_top.sv
tests/cpu_tb.sv
